// ==== include/icache_defines.svh ====
/* instruction cache configuration
   geometry of the address, the instruction and the line */

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// byte address width of the fetch port
`define ICACHE_ADDR_W 32

// one instruction, whatever the architecture
`define ICACHE_ILEN 32

// data payload of one cache line, four instructions
`define ICACHE_LINE_W 128

// number of lines, a power of two
`define ICACHE_DEPTH 64

`endif

// ==== rtl/icache_pkg.sv ====
/* instruction cache types
   address fields, payload vectors, FSM encodings and field extraction */

`include "icache_defines.svh"

package icache_pkg;

    ////////////////////
    // payload vectors
    ////////////////////

    typedef logic [`ICACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`ICACHE_ILEN-1:0]     inst_t;
    typedef logic [`ICACHE_LINE_W-1:0]   line_t;
    typedef logic [`ICACHE_LINE_W/8-1:0] strb_t;

    ////////////////////
    // address fields
    ////////////////////

    // | tag | index | offset | byte |
    typedef logic [$clog2(`ICACHE_DEPTH)-1:0]               index_t;
    typedef logic [$clog2(`ICACHE_LINE_W/`ICACHE_ILEN)-1:0] offset_t;
    // two byte bits below the offset are never used
    typedef logic [`ICACHE_ADDR_W-$bits(index_t)-$bits(offset_t)-3:0] tag_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_RESPOND,
        CTRL_REFILL,
        CTRL_WRITE_LINE,
        CTRL_FLUSH
    } ctrl_state_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA,
        FILL_DONE
    } fill_state_t;

    // word select inside the line
    function automatic offset_t addr_offset(addr_t addr);
        return addr[2 +: $bits(offset_t)];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[2 + $bits(offset_t) +: $bits(index_t)];
    endfunction

    // everything above the index
    function automatic tag_t addr_tag(addr_t addr);
        return addr[$bits(addr_t)-1 -: $bits(tag_t)];
    endfunction

endpackage

// ==== rtl/axil_pkg.sv ====
/* AXI4-Lite channel types and the few encodings the cache drives or checks */

package axil_pkg;

    ////////////////////
    // channel payloads
    ////////////////////

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;
    typedef logic [2:0]  axil_prot_t;

    // RRESP/BRESP code for a normal access
    localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

    // unprivileged, secure, instruction fetch
    localparam axil_prot_t AXIL_PROT_INSN = 3'b100;

endpackage

// ==== rtl/icache_ram.sv ====
/* simple dual-port RAM, one write port and one registered read port,
   with byte lane enables when BE_EN is set */

`timescale 1ns/1ns

module icache_ram #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 128,
    parameter bit BE_EN  = 1'b1
) (
    input  logic                    aclk,
    input  logic                    wr_en,
    input  logic [(DATA_W+7)/8-1:0] wr_be,
    input  logic [ADDR_W-1:0]       wr_addr,
    input  logic [DATA_W-1:0]       wr_data,
    input  logic [ADDR_W-1:0]       rd_addr,
    output logic [DATA_W-1:0]       rd_data
);

    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

    // power-up contents cleared so the valid bits start at zero
    initial begin
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = '0;
        end
    end

    ////////////////////
    // write port
    ////////////////////

    if (BE_EN) begin : g_byte_write
        // only the enabled byte lanes change
        always @(posedge aclk) begin
            if (wr_en) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (wr_be[b]) begin
                        mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                    end
                end
            end
        end
    end else begin : g_word_write
        // whole word, width need not be a byte multiple
        always @(posedge aclk) begin
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
        end
    end

    // read data lands the cycle after the address
    always_ff @(posedge aclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/icache_blocks.sv ====
/* direct-mapped line storage with hit/miss detection
   data and metadata RAMs, one lookup per cycle, word select on the result */

`timescale 1ns/1ns

module icache_blocks import icache_pkg::*; (
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   lookup_en,
    input  addr_t  lookup_addr,
    input  logic   wr_en,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    input  logic   wr_valid,
    input  line_t  wr_data,
    output logic   hit,
    output logic   miss,
    output inst_t  inst
);

    // stored valid bit plus tag
    localparam int META_W = 1 + $bits(tag_t);

    logic    lookup_q;
    tag_t    tag_q;
    offset_t offset_q;
    line_t   rd_line;
    logic    rd_valid;
    tag_t    rd_tag;
    logic    tag_match;

    ////////////////////
    // storage
    ////////////////////

    // refills always carry the whole line
    icache_ram #(
        .ADDR_W ($bits(index_t)),
        .DATA_W ($bits(line_t)),
        .BE_EN  (1'b1)
    ) data_ram (
        .aclk    (aclk),
        .wr_en   (wr_en),
        .wr_be   (strb_t'('1)),
        .wr_addr (wr_index),
        .wr_data (wr_data),
        .rd_addr (addr_index(lookup_addr)),
        .rd_data (rd_line)
    );

    // valid bit on top, cleared by the flush sweep
    icache_ram #(
        .ADDR_W ($bits(index_t)),
        .DATA_W (META_W),
        .BE_EN  (1'b0)
    ) meta_ram (
        .aclk    (aclk),
        .wr_en   (wr_en),
        .wr_be   ('1),
        .wr_addr (wr_index),
        .wr_data ({wr_valid, wr_tag}),
        .rd_addr (addr_index(lookup_addr)),
        .rd_data ({rd_valid, rd_tag})
    );

    ////////////////////
    // lookup result
    ////////////////////

    // flags only mean something in the cycle after a lookup
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_en;
        end
    end

    // tag and offset follow the RAM read by one cycle
    always_ff @(posedge aclk) begin
        if (lookup_en) begin
            tag_q    <= addr_tag(lookup_addr);
            offset_q <= addr_offset(lookup_addr);
        end
    end

    assign tag_match = rd_valid && (rd_tag == tag_q);
    assign hit       = lookup_q && tag_match;
    assign miss      = lookup_q && !tag_match;

    // requested word out of the registered line
    assign inst = rd_line[offset_q * $bits(inst_t) +: $bits(inst_t)];

    ////////////////////
    // checks
    ////////////////////

    // a lookup right behind a valid line write of the same address must hit
    a_write_then_hit: assert property (
        @(posedge aclk) disable iff (!aresetn)
        lookup_en && $past(wr_en && wr_valid)
            && addr_index(lookup_addr) == $past(wr_index)
            && addr_tag(lookup_addr) == $past(wr_tag)
        |=> hit
    );

    // a refill write and a lookup in one cycle would read stale metadata
    a_no_write_on_lookup: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(wr_en && lookup_en)
    );

endmodule

// ==== rtl/icache_fill.sv ====
/* AXI4-Lite read master for line refills
   four single reads, one outstanding, assembled into one line */

`timescale 1ns/1ns

module icache_fill import icache_pkg::*; import axil_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       fill_start,
    input  addr_t      fill_addr,
    output logic       fill_done,
    output line_t      fill_line,
    output axil_addr_t m_araddr,
    output axil_prot_t m_arprot,
    output logic       m_arvalid,
    input  logic       m_arready,
    input  axil_data_t m_rdata,
    input  axil_resp_t m_rresp,
    input  logic       m_rvalid,
    output logic       m_rready
);

    fill_state_t state;
    offset_t     beat;
    addr_t       base_q;

    ////////////////////
    // read sequencer
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= FILL_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (fill_start) begin
                        beat  <= '0;
                        state <= FILL_ADDR;
                    end
                end
                // address held until the slave takes it
                FILL_ADDR: begin
                    if (m_arready) begin
                        state <= FILL_DATA;
                    end
                end
                FILL_DATA: begin
                    if (m_rvalid) begin
                        beat  <= beat + 1'b1;
                        state <= (beat == '1) ? FILL_DONE : FILL_ADDR;
                    end
                end
                FILL_DONE: begin
                    state <= FILL_IDLE;
                end
                default: begin
                    state <= FILL_IDLE;
                end
            endcase
        end
    end

    // line base and assembled payload
    always_ff @(posedge aclk) begin
        if (state == FILL_IDLE && fill_start) begin
            base_q <= fill_addr;
        end
        // beat counter picks the word slot
        if (state == FILL_DATA && m_rvalid) begin
            fill_line[beat * $bits(axil_data_t) +: $bits(axil_data_t)] <= m_rdata;
        end
    end

    ////////////////////
    // bus outputs
    ////////////////////

    // word offsets 0, 4, 8 and 12 of the line
    assign m_araddr  = axil_addr_t'(base_q) + {beat, 2'b00};
    assign m_arprot  = AXIL_PROT_INSN;
    assign m_arvalid = (state == FILL_ADDR);
    assign m_rready  = (state == FILL_DATA);
    // held high for exactly one cycle
    assign fill_done = (state == FILL_DONE);

    a_araddr_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr)
    );

    // slave errors are not handled, a fill expects only OKAY beats
    a_rresp_okay: assert property (
        @(posedge aclk) disable iff (!aresetn)
        m_rvalid && m_rready |-> m_rresp == AXIL_RESP_OKAY
    );

endmodule

// ==== rtl/icache_ctrl.sv ====
/* instruction cache controller
   fetch handshake, lookup, refill sequencing and the flush sweep */

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   req_valid,
    output logic   req_ready,
    input  addr_t  req_addr,
    output logic   rsp_valid,
    input  logic   rsp_ready,
    output inst_t  rsp_inst,
    input  logic   flush_req,
    output logic   flush_busy,
    output logic   lookup_en,
    output addr_t  lookup_addr,
    input  logic   hit,
    input  logic   miss,
    input  inst_t  inst,
    output logic   fill_start,
    output addr_t  fill_addr,
    input  logic   fill_done,
    input  line_t  fill_line,
    output logic   wr_en,
    output index_t wr_index,
    output tag_t   wr_tag,
    output logic   wr_valid,
    output line_t  wr_data
);

    ctrl_state_t state;
    ctrl_state_t state_n;
    addr_t       addr_q;
    line_t       line_q;
    index_t      flush_idx;
    logic        replay;
    logic        req_fire;

    assign req_fire = req_valid && req_ready;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_n = state;
        case (state)
            // a request wins over a flush pulse in the same cycle
            CTRL_IDLE: begin
                if (req_fire) begin
                    state_n = CTRL_LOOKUP;
                end else if (flush_req) begin
                    state_n = CTRL_FLUSH;
                end
            end
            CTRL_LOOKUP: begin
                if (hit) begin
                    state_n = CTRL_RESPOND;
                end else if (miss) begin
                    state_n = CTRL_REFILL;
                end
            end
            CTRL_RESPOND: begin
                if (rsp_ready) begin
                    state_n = CTRL_IDLE;
                end
            end
            CTRL_REFILL: begin
                if (fill_done) begin
                    state_n = CTRL_WRITE_LINE;
                end
            end
            // first cycle writes, second replays the lookup
            CTRL_WRITE_LINE: begin
                if (replay) begin
                    state_n = CTRL_LOOKUP;
                end
            end
            CTRL_FLUSH: begin
                if (flush_idx == index_t'(`ICACHE_DEPTH - 1)) begin
                    state_n = CTRL_IDLE;
                end
            end
            default: begin
                state_n = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= CTRL_IDLE;
            req_ready <= 1'b0;
            replay    <= 1'b0;
            flush_idx <= '0;
        end else begin
            state     <= state_n;
            // ready only while idle, so one request in flight
            req_ready <= (state_n == CTRL_IDLE);
            replay    <= (state == CTRL_WRITE_LINE) && !replay;
            flush_idx <= (state == CTRL_FLUSH) ? flush_idx + 1'b1 : '0;
        end
    end

    // request address, response word and refilled line
    always_ff @(posedge aclk) begin
        if (req_fire) begin
            addr_q <= req_addr;
        end
        if (state == CTRL_LOOKUP && hit) begin
            rsp_inst <= inst;
        end
        if (state == CTRL_REFILL && fill_done) begin
            line_q <= fill_line;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign rsp_valid  = (state == CTRL_RESPOND);
    assign flush_busy = (state == CTRL_FLUSH);

    // new request straight from the port, a replay from the latched one
    assign lookup_en   = req_fire || (state == CTRL_WRITE_LINE && replay);
    assign lookup_addr = (state == CTRL_IDLE) ? req_addr : addr_q;

    // line-aligned base for the fill engine
    assign fill_start = (state == CTRL_LOOKUP) && miss;
    assign fill_addr  = addr_q & ~addr_t'(`ICACHE_LINE_W / 8 - 1);

    // sweep walks every index with the valid bit low
    assign wr_en    = (state == CTRL_WRITE_LINE && !replay) || (state == CTRL_FLUSH);
    assign wr_index = (state == CTRL_FLUSH) ? flush_idx : addr_index(addr_q);
    assign wr_tag   = addr_tag(addr_q);
    assign wr_valid = (state != CTRL_FLUSH);
    assign wr_data  = line_q;

    a_rsp_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_inst)
    );

endmodule

// ==== rtl/icache_top.sv ====
/* direct-mapped instruction cache with an AXI4-Lite refill port */

`timescale 1ns/1ns

module icache_top import icache_pkg::*; import axil_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    // fetch request
    input  logic       req_valid,
    output logic       req_ready,
    input  addr_t      req_addr,
    // fetch response
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output inst_t      rsp_inst,
    // flush
    input  logic       flush_req,
    output logic       flush_busy,
    // AXI4-Lite read channels
    output axil_addr_t m_araddr,
    output axil_prot_t m_arprot,
    output logic       m_arvalid,
    input  logic       m_arready,
    input  axil_data_t m_rdata,
    input  axil_resp_t m_rresp,
    input  logic       m_rvalid,
    output logic       m_rready
);

    // controller to storage
    logic   lookup_en;
    addr_t  lookup_addr;
    logic   hit;
    logic   miss;
    inst_t  inst;
    logic   wr_en;
    index_t wr_index;
    tag_t   wr_tag;
    logic   wr_valid;
    line_t  wr_data;

    // controller to fill engine
    logic   fill_start;
    addr_t  fill_addr;
    logic   fill_done;
    line_t  fill_line;

    icache_ctrl i_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_addr    (req_addr),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_inst    (rsp_inst),
        .flush_req   (flush_req),
        .flush_busy  (flush_busy),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .miss        (miss),
        .inst        (inst),
        .fill_start  (fill_start),
        .fill_addr   (fill_addr),
        .fill_done   (fill_done),
        .fill_line   (fill_line),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data)
    );

    icache_blocks i_blocks (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .hit         (hit),
        .miss        (miss),
        .inst        (inst)
    );

    icache_fill i_fill (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .m_araddr   (m_araddr),
        .m_arprot   (m_arprot),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_rdata    (m_rdata),
        .m_rresp    (m_rresp),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready)
    );

endmodule

// ==== tb/axil_mem_model.sv ====
/* AXI4-Lite read slave for the cache testbench
   returns the address XOR a fixed pattern after a variable number of wait cycles */

`timescale 1ns/1ns

module axil_mem_model import axil_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    // wait cycles before arready and before rvalid
    input  logic [2:0] ar_wait,
    input  logic [2:0] r_wait,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output axil_data_t rdata,
    output axil_resp_t rresp,
    output logic       rvalid,
    input  logic       rready
);

    localparam axil_data_t MEM_PATTERN = 32'h5a5a_a5a5;

    // 0 waits for an address, 1 counts down to the data beat, 2 holds the beat
    int         phase;
    int         wait_cnt;
    axil_addr_t addr_q;
    logic       r_taken;

    initial begin
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rresp    = 2'b00;
        phase    = 0;
        wait_cnt = 0;
        addr_q   = '0;
        r_taken  = 1'b0;
    end

    ////////////////////
    // slave sequencer
    ////////////////////

    // outputs move on the falling edge, the cache samples them on the rising edge
    always @(negedge aclk) begin
        if (!aresetn) begin
            arready  = 1'b0;
            rvalid   = 1'b0;
            phase    = 0;
            wait_cnt = 0;
        end else begin
            case (phase)
                0: begin
                    if (arvalid) begin
                        if (wait_cnt >= int'(ar_wait)) begin
                            // arvalid is stable until the next rising edge
                            arready  = 1'b1;
                            addr_q   = araddr;
                            wait_cnt = 0;
                            phase    = 1;
                        end else begin
                            wait_cnt = wait_cnt + 1;
                        end
                    end
                end
                // address went across at the last rising edge
                1: begin
                    arready = 1'b0;
                    if (wait_cnt >= int'(r_wait)) begin
                        rvalid  = 1'b1;
                        rdata   = addr_q ^ MEM_PATTERN;
                        rresp   = 2'b00;
                        r_taken = rready;
                        phase   = 2;
                    end else begin
                        wait_cnt = wait_cnt + 1;
                    end
                end
                default: begin
                    // beat held until rready was seen at a rising edge
                    if (r_taken) begin
                        rvalid   = 1'b0;
                        wait_cnt = 0;
                        phase    = 0;
                    end else begin
                        r_taken = rready;
                    end
                end
            endcase
        end
    end

endmodule

// ==== tb/icache_tb.sv ====
/* instruction cache testbench
   table of fetches and flushes against an AXI4-Lite memory model */

`timescale 1ns/1ns

`include "icache_defines.svh"

module icache_tb import icache_pkg::*; import axil_pkg::*; ();

    localparam int    NUM_ROWS    = 20;
    localparam int    OP_FETCH    = 0;
    localparam int    OP_FLUSH    = 1;
    // stall column value that asks for a random stall
    localparam int    STALL_RND   = -1;
    localparam inst_t MEM_PATTERN = 32'h5a5a_a5a5;
    localparam logic [31:0] RNG_SEED = 32'hc0b3;
    // worst refill is four beats of up to 8+8 wait cycles plus handshakes
    localparam int    REFILL_CYCLES = 4 * (8 + 8 + 4);
    localparam int    ROW_CYCLES    = REFILL_CYCLES + `ICACHE_DEPTH + 16;
    localparam int    CYCLE_LIMIT   = 10 + NUM_ROWS * ROW_CYCLES;

    logic       aclk;
    logic       aresetn;
    logic       req_valid;
    logic       req_ready;
    addr_t      req_addr;
    logic       rsp_valid;
    logic       rsp_ready;
    inst_t      rsp_inst;
    logic       flush_req;
    logic       flush_busy;
    axil_addr_t m_araddr;
    axil_prot_t m_arprot;
    logic       m_arvalid;
    logic       m_arready;
    axil_data_t m_rdata;
    axil_resp_t m_rresp;
    logic       m_rvalid;
    logic       m_rready;
    logic [2:0] ar_wait;
    logic [2:0] r_wait;

    // operation table, one row per fetch or flush
    int    n_rows = 0;
    int    row_op    [NUM_ROWS];
    addr_t row_addr  [NUM_ROWS];
    logic  row_fill  [NUM_ROWS];
    int    row_stall [NUM_ROWS];

    logic [31:0] rng_state;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_cnt = 0;
    int          ar_count = 0;
    addr_t       ar_addrs [$];

    always #50 aclk = ~aclk;

    icache_top i_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_inst   (rsp_inst),
        .flush_req  (flush_req),
        .flush_busy (flush_busy),
        .m_araddr   (m_araddr),
        .m_arprot   (m_arprot),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .m_rdata    (m_rdata),
        .m_rresp    (m_rresp),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready)
    );

    axil_mem_model i_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ar_wait (ar_wait),
        .r_wait  (r_wait),
        .araddr  (m_araddr),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rvalid  (m_rvalid),
        .rready  (m_rready)
    );

    ////////////////////
    // random delays, AR monitor, timeout
    ////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // new wait cycles for the memory model every clock
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rng_state <= RNG_SEED;
            ar_wait   <= '0;
            r_wait    <= '0;
        end else begin
            rng_state <= xorshift32(rng_state);
            ar_wait   <= rng_state[2:0];
            r_wait    <= rng_state[6:4];
        end
    end

    // every address that crosses the AR channel
    always @(posedge aclk) begin
        if (m_arvalid && m_arready) begin
            ar_count = ar_count + 1;
            ar_addrs.push_back(m_araddr);
            // unprivileged, secure, instruction access
            if (m_arprot !== 3'b100) begin
                report_mismatch("m_arprot", 32'(m_arprot), 32'h4);
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Fail %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        value_errors++;
    endtask

    task automatic report_problem(string msg);
        $display("error: %s at %0t", msg, $time);
        other_errors++;
    endtask

    task automatic add_row(int op, addr_t addr, logic fill, int stall);
        row_op[n_rows]    = op;
        row_addr[n_rows]  = addr;
        row_fill[n_rows]  = fill;
        row_stall[n_rows] = stall;
        n_rows++;
    endtask

    // index is addr[9:4], tag is addr[31:10]
    task automatic load_table();
        add_row(OP_FETCH, 32'h0000_1000, 1'b1, 0);
        add_row(OP_FETCH, 32'h0000_1004, 1'b0, 0);
        add_row(OP_FETCH, 32'h0000_1008, 1'b0, 1);
        add_row(OP_FETCH, 32'h0000_100c, 1'b0, 0);
        add_row(OP_FETCH, 32'h0000_1000, 1'b0, 3);
        // same index as 0x1000, other tag
        add_row(OP_FETCH, 32'h0000_1400, 1'b1, 0);
        add_row(OP_FETCH, 32'h0000_1404, 1'b0, 0);
        add_row(OP_FETCH, 32'h0000_1000, 1'b1, 0);
        add_row(OP_FETCH, 32'h0000_2050, 1'b1, 0);
        add_row(OP_FETCH, 32'h0000_2058, 1'b0, 0);
        add_row(OP_FLUSH, 32'h0000_0000, 1'b0, 0);
        add_row(OP_FETCH, 32'h0000_1008, 1'b1, 0);
        add_row(OP_FETCH, 32'h0000_2054, 1'b1, STALL_RND);
        add_row(OP_FETCH, 32'h0000_100c, 1'b0, STALL_RND);
        add_row(OP_FETCH, 32'h0000_3ff0, 1'b1, STALL_RND);
        add_row(OP_FETCH, 32'h0000_3ffc, 1'b0, STALL_RND);
        add_row(OP_FETCH, 32'h0000_2050, 1'b0, STALL_RND);
        add_row(OP_FETCH, 32'h0000_1000, 1'b0, STALL_RND);
        add_row(OP_FETCH, 32'h8000_0120, 1'b1, STALL_RND);
        add_row(OP_FETCH, 32'h8000_012c, 1'b0, STALL_RND);
    endtask

    ////////////////////
    // row execution
    ////////////////////

    task automatic run_fetch(int r);
        addr_t addr;
        addr_t base;
        inst_t exp_inst;
        int    first_ar;
        int    lat;
        int    stall;
        addr = row_addr[r];
        base = addr & ~addr_t'(15);
        exp_inst = (addr & ~addr_t'(3)) ^ MEM_PATTERN;
        req_valid = 1'b1;
        req_addr  = addr;
        // handshake at the next rising edge once req_ready is seen
        while (!req_ready) begin
            @(negedge aclk);
        end
        first_ar = ar_count;
        @(negedge aclk);
        req_valid = 1'b0;
        lat = 1;
        while (!rsp_valid) begin
            if (req_ready) begin
                report_problem("req_ready high while a fetch is in flight");
            end
            @(negedge aclk);
            lat++;
        end
        if (rsp_inst !== exp_inst) begin
            report_mismatch("rsp_inst", rsp_inst, exp_inst);
        end
        if (row_fill[r]) begin
            // four single reads at the line base plus 0, 4, 8 and 12
            if (ar_count - first_ar != 4) begin
                report_mismatch("AR handshakes", 32'(ar_count - first_ar), 32'd4);
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (ar_addrs[first_ar + k] !== base + addr_t'(4 * k)) begin
                        report_mismatch("m_araddr", ar_addrs[first_ar + k],
                                        base + addr_t'(4 * k));
                    end
                end
            end
        end else begin
            if (ar_count != first_ar) begin
                report_mismatch("AR handshakes", 32'(ar_count - first_ar), 32'd0);
            end
            if (lat != 2) begin
                report_mismatch("rsp_valid latency", 32'(lat), 32'd2);
            end
        end
        // response must hold through the stall
        stall = (row_stall[r] == STALL_RND) ? int'(rng_state[9:8]) + 1 : row_stall[r];
        repeat (stall) begin
            @(negedge aclk);
            if (rsp_valid !== 1'b1) begin
                report_mismatch("rsp_valid", 32'(rsp_valid), 32'd1);
            end
            if (rsp_inst !== exp_inst) begin
                report_mismatch("rsp_inst", rsp_inst, exp_inst);
            end
        end
        rsp_ready = 1'b1;
        @(negedge aclk);
        rsp_ready = 1'b0;
        if (rsp_valid) begin
            report_problem("rsp_valid still high after the response handshake");
        end
    endtask

    task automatic run_flush(int r);
        int n;
        while (!req_ready) begin
            @(negedge aclk);
        end
        flush_req = 1'b1;
        @(negedge aclk);
        flush_req = 1'b0;
        n = 1;
        if (!flush_busy) begin
            report_problem("flush_busy did not rise after flush_req");
        end
        while (flush_busy) begin
            if (req_ready) begin
                report_problem("req_ready high during the flush sweep");
            end
            @(negedge aclk);
            n++;
        end
        // pulse to falling edge of flush_busy
        if (n != `ICACHE_DEPTH + 1) begin
            report_mismatch("flush_busy length", 32'(n), 32'(`ICACHE_DEPTH + 1));
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        aclk      = 1'b0;
        aresetn   = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        rsp_ready = 1'b0;
        flush_req = 1'b0;
        load_table();
        repeat (3) @(negedge aclk);
        // outputs quiet under reset
        if (rsp_valid !== 1'b0) begin
            report_mismatch("rsp_valid", 32'(rsp_valid), 32'd0);
        end
        if (m_arvalid !== 1'b0) begin
            report_mismatch("m_arvalid", 32'(m_arvalid), 32'd0);
        end
        if (m_rready !== 1'b0) begin
            report_mismatch("m_rready", 32'(m_rready), 32'd0);
        end
        if (flush_busy !== 1'b0) begin
            report_mismatch("flush_busy", 32'(flush_busy), 32'd0);
        end
        if (req_ready !== 1'b0) begin
            report_mismatch("req_ready", 32'(req_ready), 32'd0);
        end
        aresetn = 1'b1;
        @(negedge aclk);
        if (req_ready !== 1'b1) begin
            report_mismatch("req_ready", 32'(req_ready), 32'd1);
        end
        for (int r = 0; r < n_rows; r++) begin
            if (row_op[r] == OP_FLUSH) begin
                run_flush(r);
            end else begin
                run_fetch(r);
            end
        end
        $display("errors: %0d value, %0d other, %0d AR handshakes", value_errors,
                 other_errors, ar_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== icache_top.f ====
+incdir+include
rtl/icache_pkg.sv
rtl/axil_pkg.sv
rtl/icache_ram.sv
rtl/icache_blocks.sv
rtl/icache_fill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/axil_mem_model.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f icache_top.f -o icache_sim &&
out=$(./obj_dir/icache_sim) &&
echo "$out" &&
echo "$out" | grep -q "^TESTS PASSED$" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }
